// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     ?= tb_core
RTL_TOP    ?= core_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --assert
PASS_MSG   ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/fetch_ctrl.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_unit.sv
source/core_top.sv
tests/tb_clock.sv
tests/core_assert.sv
tests/tb_core.sv

// ==== source/core_cfg_pkg.sv ====
package core_cfg_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Architectural register file
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = 5;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

// ==== source/core_top.sv ====
module core_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_exec,
    input  logic                   i_inst_valid,
    input  core_cfg_pkg::word_t    i_inst,
    input  core_cfg_pkg::reg_idx_t i_dbg_idx,
    output logic                   o_fetch_req,
    output core_cfg_pkg::word_t    o_fetch_pc,
    output core_cfg_pkg::word_t    o_pc,
    output core_cfg_pkg::word_t    o_dbg_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // Fetch to execute
    logic       exec_valid;
    word_t      exec_inst;
    word_t      exec_pc;

    // Decode results
    inst_kind_e kind;
    alu_op_e    alu_op;
    word_t      imm;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      rs1_data;
    word_t      rs2_data;

    // Retire
    logic       wr_en;
    reg_idx_t   wr_idx;
    word_t      wr_data;
    logic       jump;
    word_t      jump_pc;

    fetch_ctrl u_fetch_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec      (i_exec),
        .i_inst_valid(i_inst_valid),
        .i_inst      (i_inst),
        .i_jump      (jump),
        .i_jump_pc   (jump_pc),
        .o_fetch_req (o_fetch_req),
        .o_fetch_pc  (o_fetch_pc),
        .o_exec_valid(exec_valid),
        .o_exec_inst (exec_inst),
        .o_exec_pc   (exec_pc)
    );

    inst_decode u_inst_decode (
        .i_inst  (exec_inst),
        .o_kind  (kind),
        .o_alu_op(alu_op),
        .o_imm   (imm),
        .o_rd    (rd),
        .o_rs1   (rs1),
        .o_rs2   (rs2)
    );

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .i_dbg_idx (i_dbg_idx),
        .i_wr_en   (wr_en),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data),
        .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data),
        .o_dbg_data(o_dbg_data)
    );

    exec_unit u_exec_unit (
        .i_valid   (exec_valid),
        .i_pc      (exec_pc),
        .i_kind    (kind),
        .i_alu_op  (alu_op),
        .i_imm     (imm),
        .i_rd      (rd),
        .i_rs1_data(rs1_data),
        .i_rs2_data(rs2_data),
        .o_wr_en   (wr_en),
        .o_wr_idx  (wr_idx),
        .o_wr_data (wr_data),
        .o_jump    (jump),
        .o_jump_pc (jump_pc)
    );

    // Debug view of the program counter
    assign o_pc = exec_pc;

endmodule

// ==== source/exec_unit.sv ====
module exec_unit (
    input  logic                   i_valid,
    input  core_cfg_pkg::word_t    i_pc,
    input  rv_isa_pkg::inst_kind_e i_kind,
    input  rv_isa_pkg::alu_op_e    i_alu_op,
    input  core_cfg_pkg::word_t    i_imm,
    input  core_cfg_pkg::reg_idx_t i_rd,
    input  core_cfg_pkg::word_t    i_rs1_data,
    input  core_cfg_pkg::word_t    i_rs2_data,
    output logic                   o_wr_en,
    output core_cfg_pkg::reg_idx_t o_wr_idx,
    output core_cfg_pkg::word_t    o_wr_data,
    output logic                   o_jump,
    output core_cfg_pkg::word_t    o_jump_pc
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    word_t op_b;
    word_t alu_res;
    word_t pc_plus4;
    logic  wr_en;
    logic  jump;

    // Branches compare two registers
    assign op_b = (i_kind == KIND_ALU_REG || i_kind == KIND_BRANCH) ? i_rs2_data : i_imm;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_ADD:  alu_res = i_rs1_data + op_b;
            ALU_SUB:  alu_res = i_rs1_data - op_b;
            ALU_SLL:  alu_res = i_rs1_data << op_b[4:0];
            ALU_SLT:  alu_res = word_t'($signed(i_rs1_data) < $signed(op_b));
            ALU_SLTU: alu_res = word_t'(i_rs1_data < op_b);
            ALU_XOR:  alu_res = i_rs1_data ^ op_b;
            ALU_SRL:  alu_res = i_rs1_data >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(i_rs1_data) >>> op_b[4:0];
            ALU_OR:   alu_res = i_rs1_data | op_b;
            ALU_AND:  alu_res = i_rs1_data & op_b;
            ALU_SEQ:  alu_res = word_t'(i_rs1_data == op_b);
            ALU_SNE:  alu_res = word_t'(i_rs1_data != op_b);
            default:  alu_res = '0;
        endcase
    end

    assign pc_plus4 = i_pc + 32'd4;

    // ------------------------------
    // Writeback and next PC
    // ------------------------------
    always_comb begin
        wr_en     = 1'b0;
        jump      = 1'b0;
        o_wr_data = alu_res;
        case (i_kind)
            KIND_ALU_REG, KIND_ALU_IMM: wr_en = 1'b1;
            KIND_LUI: begin
                wr_en     = 1'b1;
                o_wr_data = i_imm;
            end
            KIND_JAL: begin
                wr_en     = 1'b1;
                jump      = 1'b1;
                o_wr_data = pc_plus4;
            end
            KIND_BRANCH: jump = alu_res[0];
            default: wr_en = 1'b0;
        endcase
    end

    assign o_wr_en   = i_valid & wr_en;
    assign o_wr_idx  = i_rd;
    assign o_jump    = i_valid & jump;
    assign o_jump_pc = i_pc + i_imm;

endmodule

// ==== source/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_exec,
    input  logic                i_inst_valid,
    input  core_cfg_pkg::word_t i_inst,
    input  logic                i_jump,
    input  core_cfg_pkg::word_t i_jump_pc,
    output logic                o_fetch_req,
    output core_cfg_pkg::word_t o_fetch_pc,
    output logic                o_exec_valid,
    output core_cfg_pkg::word_t o_exec_inst,
    output core_cfg_pkg::word_t o_exec_pc
);
    import core_cfg_pkg::*;

    // Sequencer is idle when neither flag is set
    logic  req_q;
    logic  exec_q;
    word_t pc_q;
    word_t inst_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            req_q  <= 1'b0;
            exec_q <= 1'b0;
            pc_q   <= RESET_PC;
        end else begin
            exec_q <= 1'b0;
            if (exec_q) begin
                // Retire and go straight to the next request
                pc_q  <= i_jump ? i_jump_pc : pc_q + 32'd4;
                req_q <= i_exec;
            end else if (req_q) begin
                if (i_inst_valid) begin
                    req_q  <= 1'b0;
                    exec_q <= 1'b1;
                end
            end else if (i_exec) begin
                req_q <= 1'b1;
            end
        end
    end

    // Instruction hold register
    always_ff @(posedge i_clk) begin
        if (req_q && i_inst_valid) begin
            inst_q <= i_inst;
        end
    end

    assign o_fetch_req  = req_q;
    assign o_fetch_pc   = pc_q;
    assign o_exec_valid = exec_q;
    assign o_exec_inst  = inst_q;
    assign o_exec_pc    = pc_q;

endmodule

// ==== source/inst_decode.sv ====
module inst_decode (
    input  core_cfg_pkg::word_t    i_inst,
    output rv_isa_pkg::inst_kind_e o_kind,
    output rv_isa_pkg::alu_op_e    o_alu_op,
    output core_cfg_pkg::word_t    o_imm,
    output core_cfg_pkg::reg_idx_t o_rd,
    output core_cfg_pkg::reg_idx_t o_rs1,
    output core_cfg_pkg::reg_idx_t o_rs2
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    inst_u   word;
    alu_op_e base_op;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm_b;

    assign word  = i_inst;
    assign o_rd  = word.r.rd;
    assign o_rs1 = word.r.rs1;
    assign o_rs2 = word.r.rs2;

    // ------------------------------
    // Immediates
    // ------------------------------
    assign imm_i = {{20{word.i.imm12[11]}}, word.i.imm12};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

    // Operation by funct3 alone
    always_comb begin
        base_op = ALU_ADD;
        case (word.r.funct3)
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            F3_AND:     base_op = ALU_AND;
            default:    base_op = ALU_ADD;
        endcase
    end

    // ------------------------------
    // Classification
    // ------------------------------
    always_comb begin
        o_kind   = KIND_NOP;
        o_alu_op = ALU_ADD;
        o_imm    = '0;
        case (word.r.opcode)
            OPC_LUI: begin
                o_kind = KIND_LUI;
                o_imm  = imm_u;
            end
            OPC_JAL: begin
                o_kind = KIND_JAL;
                o_imm  = imm_j;
            end
            OPC_OP_IMM: begin
                o_kind   = KIND_ALU_IMM;
                o_imm    = imm_i;
                o_alu_op = base_op;
                // SRAI sets bit 10 of the immediate
                if (word.i.funct3 == F3_SRL_SRA && word.i.imm12[10]) begin
                    o_alu_op = ALU_SRA;
                end
            end
            OPC_OP: begin
                if (word.r.funct7 == 7'b0) begin
                    o_kind   = KIND_ALU_REG;
                    o_alu_op = base_op;
                end else if (word.r.funct7 == FUNCT7_ALT) begin
                    if (word.r.funct3 == F3_ADD_SUB) begin
                        o_kind   = KIND_ALU_REG;
                        o_alu_op = ALU_SUB;
                    end else if (word.r.funct3 == F3_SRL_SRA) begin
                        o_kind   = KIND_ALU_REG;
                        o_alu_op = ALU_SRA;
                    end
                end
            end
            OPC_BRANCH: begin
                o_imm = imm_b;
                if (word.r.funct3 == F3_BEQ) begin
                    o_kind   = KIND_BRANCH;
                    o_alu_op = ALU_SEQ;
                end else if (word.r.funct3 == F3_BNE) begin
                    o_kind   = KIND_BRANCH;
                    o_alu_op = ALU_SNE;
                end
            end
            default: o_kind = KIND_NOP;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
module reg_file (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  core_cfg_pkg::reg_idx_t i_rs1,
    input  core_cfg_pkg::reg_idx_t i_rs2,
    input  core_cfg_pkg::reg_idx_t i_dbg_idx,
    input  logic                   i_wr_en,
    input  core_cfg_pkg::reg_idx_t i_wr_idx,
    input  core_cfg_pkg::word_t    i_wr_data,
    output core_cfg_pkg::word_t    o_rs1_data,
    output core_cfg_pkg::word_t    o_rs2_data,
    output core_cfg_pkg::word_t    o_dbg_data
);
    import core_cfg_pkg::*;

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx != '0)) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // Index 0 reads as zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];
    assign o_dbg_data = (i_dbg_idx == '0) ? '0 : regs[i_dbg_idx];

endmodule

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ------------------------------
    // funct3 codes
    // ------------------------------
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Selects SUB / SRA
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // SEQ and SNE give 1 or 0 and drive the branch decision
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_SEQ,
        ALU_SNE
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_ALU_REG,
        KIND_ALU_IMM,
        KIND_LUI,
        KIND_JAL,
        KIND_BRANCH,
        KIND_NOP
    } inst_kind_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // One fetched word seen two ways
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

endpackage

// ==== tests/core_assert.sv ====
module core_assert (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_inst_valid,
    input logic                i_fetch_req,
    input core_cfg_pkg::word_t i_fetch_pc,
    input logic                i_exec_valid
);

    // Request and address hold until memory answers
    property req_held;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_fetch_req && !i_inst_valid |=> i_fetch_req && $stable(i_fetch_pc);
    endproperty

    // No request comes out of a reset cycle
    property no_req_in_reset;
        @(posedge i_clk) !i_rst_n |=> !i_fetch_req;
    endproperty

    // Execute strobe is a single cycle
    property exec_one_cycle;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_exec_valid |=> !i_exec_valid;
    endproperty

    a_req_held: assert property (req_held)
        else $error("fetch request dropped or moved before the memory strobe");
    a_no_req_in_reset: assert property (no_req_in_reset)
        else $error("fetch request raised during reset");
    a_exec_one_cycle: assert property (exec_one_cycle)
        else $error("exec_valid held for more than one cycle");

endmodule

bind fetch_ctrl core_assert u_core_assert (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_inst_valid(i_inst_valid),
    .i_fetch_req (o_fetch_req),
    .i_fetch_pc  (o_fetch_pc),
    .i_exec_valid(o_exec_valid)
);

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic o_clk
);

    // Period of 40
    localparam int HALF_PERIOD = 20;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

// ==== tests/tb_core.sv ====
module tb_core;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int    DRIVE_DLY    = 2;
    localparam int    PROG_LEN     = 33;
    localparam word_t END_PC       = 32'd128;
    localparam int    RUN_TIMEOUT  = 1000;
    localparam int    IDLE_TIMEOUT = 50;
    localparam int    IDLE_CYCLES  = 4;
    localparam word_t NOP_WORD     = 32'h0000_0013;

    // Register file after the program with four registers per row from x0
    localparam word_t EXP_REGS [NUM_REGS] = '{
        32'h0000_0000, 32'h8000_0000, 32'hffff_fffb, 32'h0000_0007,
        32'h0000_0000, 32'h0000_0001, 32'h0000_00f7, 32'h0000_0107,
        32'h0000_00fb, 32'h0000_0070, 32'h0000_000f, 32'hf800_0000,
        32'h0000_0002, 32'h0000_000c, 32'h0000_0380, 32'h0000_0001,
        32'h0000_0000, 32'hffff_fffc, 32'hffff_ffff, 32'h0000_0003,
        32'h0100_0000, 32'hff00_0000, 32'h0000_0000, 32'h0000_0000,
        32'h0000_0055, 32'h0000_0066, 32'h0000_007c, 32'h0000_0000,
        32'h0000_0084, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000
    };

    logic        clk;
    logic        rst_n;
    logic        exec_en;
    logic        inst_valid;
    word_t       inst;
    reg_idx_t    dbg_idx;
    logic        fetch_req;
    word_t       fetch_pc;
    word_t       pc;
    word_t       dbg_data;

    word_t       prog [PROG_LEN];
    logic [31:0] lcg_state = 32'hf1ac7f6b;
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;

    tb_clock u_clock (
        .o_clk(clk)
    );

    core_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_exec      (exec_en),
        .i_inst_valid(inst_valid),
        .i_inst      (inst),
        .i_dbg_idx   (dbg_idx),
        .o_fetch_req (fetch_req),
        .o_fetch_pc  (fetch_pc),
        .o_pc        (pc),
        .o_dbg_data  (dbg_data)
    );

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic word_t itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t rtype_word(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t branch_word(input logic [12:0] off, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic load_program();
        prog = '{
            lui_word(20'h80000, 5'd1),
            itype_word(12'hffb, 5'd0, F3_ADD_SUB, 5'd2),
            itype_word(12'h007, 5'd0, F3_ADD_SUB, 5'd3),
            itype_word(12'hfff, 5'd3, F3_SLT, 5'd4),
            itype_word(12'hfff, 5'd3, F3_SLTU, 5'd5),
            itype_word(12'h0f0, 5'd3, F3_XOR, 5'd6),
            itype_word(12'h100, 5'd3, F3_OR, 5'd7),
            itype_word(12'h0ff, 5'd2, F3_AND, 5'd8),
            itype_word(12'h004, 5'd3, F3_SLL, 5'd9),
            itype_word(12'h01c, 5'd2, F3_SRL_SRA, 5'd10),
            itype_word(12'h404, 5'd1, F3_SRL_SRA, 5'd11),
            rtype_word(7'h00, 5'd3, 5'd2, F3_ADD_SUB, 5'd12),
            rtype_word(FUNCT7_ALT, 5'd2, 5'd3, F3_ADD_SUB, 5'd13),
            rtype_word(7'h00, 5'd3, 5'd3, F3_SLL, 5'd14),
            rtype_word(7'h00, 5'd3, 5'd2, F3_SLT, 5'd15),
            rtype_word(7'h00, 5'd3, 5'd2, F3_SLTU, 5'd16),
            rtype_word(7'h00, 5'd3, 5'd2, F3_XOR, 5'd17),
            rtype_word(7'h00, 5'd3, 5'd2, F3_OR, 5'd18),
            rtype_word(7'h00, 5'd3, 5'd2, F3_AND, 5'd19),
            rtype_word(7'h00, 5'd3, 5'd1, F3_SRL_SRA, 5'd20),
            rtype_word(FUNCT7_ALT, 5'd3, 5'd1, F3_SRL_SRA, 5'd21),
            itype_word(12'h005, 5'd3, F3_ADD_SUB, 5'd0),      // rd is x0
            branch_word(13'd8, 5'd3, 5'd3, F3_BEQ),          // taken
            itype_word(12'h001, 5'd0, F3_ADD_SUB, 5'd22),
            branch_word(13'd8, 5'd2, 5'd3, F3_BNE),          // taken
            itype_word(12'h001, 5'd0, F3_ADD_SUB, 5'd23),
            branch_word(13'd8, 5'd2, 5'd3, F3_BEQ),
            itype_word(12'h055, 5'd0, F3_ADD_SUB, 5'd24),
            branch_word(13'd8, 5'd3, 5'd3, F3_BNE),
            itype_word(12'h066, 5'd0, F3_ADD_SUB, 5'd25),
            jal_word(21'd8, 5'd26),
            itype_word(12'h001, 5'd0, F3_ADD_SUB, 5'd27),
            jal_word(21'd0, 5'd28)                           // loops on itself
        };
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t lookup_inst(input word_t addr);
        if (addr[1:0] != 2'b00 || addr >= PROG_LEN * 4) begin
            failures++;
            $display("Fetch at address %h falls outside the program", addr);
            return NOP_WORD;
        end else begin
            return prog[addr[7:2]];
        end
    endfunction

    // Answers each request after 0 to 3 idle cycles
    initial begin : mem_model
        logic [31:0] rnd;
        int          delay;
        inst_valid = 1'b0;
        inst       = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            inst_valid = 1'b0;
            if (fetch_req) begin
                rnd   = next_rand();
                delay = int'(rnd[31:30]);
                for (int n = 0; n < delay; n++) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
                inst       = lookup_inst(fetch_pc);
                inst_valid = 1'b1;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // Reads every register through the debug port
    task automatic check_regs(input string phase, input logic after_run);
        word_t expected;
        for (int idx = 0; idx < NUM_REGS; idx++) begin
            @(posedge clk);
            #DRIVE_DLY;
            dbg_idx = reg_idx_t'(idx);
            @(negedge clk);
            expected = after_run ? EXP_REGS[idx] : '0;
            check_word($sformatf("%s x%0d", phase, idx), expected, dbg_data);
        end
    endtask

    task automatic wait_for_pc(input word_t target, output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            ok = (pc == target);
            cycles++;
        end
        if (!ok) begin
            failures++;
            $display("Timeout: program counter never reached %h", target);
        end
    endtask

    task automatic wait_for_idle(output logic ok);
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < IDLE_CYCLES && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            quiet = fetch_req ? 0 : quiet + 1;
            cycles++;
        end
        ok = (quiet >= IDLE_CYCLES);
        if (!ok) begin
            failures++;
            $display("Timeout: core kept fetching after exec was lowered");
        end
    endtask

    initial begin : main
        logic ok;
        rst_n   = 1'b0;
        exec_en = 1'b0;
        dbg_idx = '0;
        load_program();
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Idle after reset
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_bit("idle fetch_req", 1'b0, fetch_req);
            check_word("idle pc", RESET_PC, pc);
        end
        check_regs("reset", 1'b0);

        @(posedge clk);
        #DRIVE_DLY;
        exec_en = 1'b1;
        wait_for_pc(END_PC, ok);
        if (ok) begin
            @(posedge clk);
            #DRIVE_DLY;
            exec_en = 1'b0;
            wait_for_idle(ok);
        end
        if (ok) begin
            check_word("final pc", END_PC, pc);
            check_regs("final", 1'b1);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
